//--- src/game_pkg.sv
package game_pkg;

    typedef logic [9:0] coord_t;         // Pixel coordinate on either axis.
    typedef logic signed [7:0] vel_t;
    typedef logic [1:0] grav_t;          // Steps since the last gravity kick.

    // The states of the rally FSM.
    typedef enum logic [2:0] {
        st_idle,
        st_wait,
        st_win_flag,
        st_wait_win_flag,
        st_running_right,
        st_running_left,
        st_stop,
        st_send_ball
    } rally_state_t;

    localparam coord_t start_y = 10'd220;
    localparam vel_t start_vy = -8'sd3;
    localparam coord_t x_step = 10'd10;

    localparam coord_t right_edge_small = 10'd300;
    localparam coord_t right_edge_large = 10'd620;
    localparam coord_t y_max_small = 10'd239;
    localparam coord_t y_max_large = 10'd479;

    localparam coord_t paddle_col = 10'd20;   // The paddle can hit at or left of this column.
    localparam coord_t paddle_h = 10'd40;

endpackage

//--- src/link_pkg.sv
package link_pkg;

    typedef logic [7:0] link_byte_t;

    localparam int frame_len = 6;

    // Byte positions in a frame, in the order they go on the link.
    localparam int idx_y_hi = 0;
    localparam int idx_y_lo = 1;
    localparam int idx_vy = 2;
    localparam int idx_grav = 3;
    localparam int idx_speed = 4;
    localparam int idx_win = 5;

    localparam int flag_bit = 0;    // Speed and win flags sit in this bit.

    // Bits 9:8 of y travel in the top two bits of the high byte.
    localparam int y_hi_lsb = 6;

endpackage

//--- src/paddle_speed_estimator.sv
`timescale 1ns/1ps

module paddle_speed_estimator (
    input  logic             clk_25MHZ,
    input  logic             reset,
    input  game_pkg::coord_t paddle_y,
    input  logic             frame_tick,
    output game_pkg::coord_t estimated_speed
);
    import game_pkg::*;

    coord_t prev_y;
    coord_t delta_y;

    // Distance moved since the last video frame, in either direction.
    assign delta_y = (paddle_y >= prev_y) ? paddle_y - prev_y : prev_y - paddle_y;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            prev_y <= '0;
            estimated_speed <= '0;
        end else if (frame_tick) begin
            prev_y <= paddle_y;
            estimated_speed <= delta_y;
        end
    end

endmodule

//--- src/collision_checker.sv
`timescale 1ns/1ps

module collision_checker (
    input  logic             clk_25MHZ,
    input  logic             reset,
    input  game_pkg::coord_t ball_x,
    input  game_pkg::coord_t ball_y,
    input  game_pkg::coord_t paddle_y,
    input  logic             moving_left,
    output logic             collision
);
    import game_pkg::*;

    logic [10:0] paddle_bottom;   // One bit wider so a low paddle cannot wrap.
    logic        overlap;
    logic        hit_seen;

    assign paddle_bottom = {1'b0, paddle_y} + {1'b0, paddle_h};

    assign overlap = moving_left && (ball_x <= paddle_col) &&
                     (ball_y >= paddle_y) && ({1'b0, ball_y} <= paddle_bottom);

    // Only the first cycle of an overlap counts as a hit.
    assign collision = overlap && !hit_seen;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            hit_seen <= 1'b0;
        end else begin
            hit_seen <= overlap;
        end
    end

endmodule

//--- src/rally_controller.sv
`timescale 1ns/1ps

module rally_controller #(
    parameter int unsigned base_step_cycles = 270000
) (
    input  logic                 clk_25MHZ,
    input  logic                 reset,
    input  logic                 upscale,
    input  logic                 game_start,
    input  logic                 collision,
    input  game_pkg::coord_t     estimated_speed,
    input  logic                 frame_ready,
    input  logic                 send_done,
    input  link_pkg::link_byte_t rx_y_hi,
    input  link_pkg::link_byte_t rx_y_lo,
    input  link_pkg::link_byte_t rx_vy,
    input  link_pkg::link_byte_t rx_grav,
    input  link_pkg::link_byte_t rx_speed,
    input  link_pkg::link_byte_t rx_win,
    output game_pkg::coord_t     ball_x,
    output game_pkg::coord_t     ball_y,
    output logic                 moving_left,
    output logic                 moving_right,
    output logic                 game_over,
    output logic                 send_trigger,
    output game_pkg::vel_t       ball_vy,
    output game_pkg::grav_t      gravity_phase,
    output logic                 ball_fast,
    output logic                 is_you_win,
    output logic                 responding,
    output logic [7:0]           contrl_led
);
    import game_pkg::*;
    import link_pkg::*;

    localparam int cnt_w = $clog2(base_step_cycles + 1);
    localparam logic [cnt_w-1:0] full_period = cnt_w'(base_step_cycles);

    rally_state_t state, state_next;

    coord_t ball_x_next;
    coord_t ball_y_next;
    coord_t y_max;
    coord_t right_edge;
    coord_t y_step;
    coord_t divisor;
    vel_t ball_vy_next;
    vel_t vy_step;
    grav_t grav_next;
    logic signed [11:0] y_sum;
    logic [cnt_w-1:0] step_cnt, step_cnt_next;
    logic [cnt_w-1:0] step_period, step_period_next;
    logic [cnt_w-1:0] hit_period;
    logic step_tick;
    logic do_step;
    logic serve;
    logic game_over_next;
    logic send_trigger_next;
    logic is_you_win_next;

    assign y_max = upscale ? y_max_large : y_max_small;
    assign right_edge = upscale ? right_edge_large : right_edge_small;
    assign step_tick = (step_cnt >= step_period - 1'b1);
    assign ball_fast = (step_period < full_period);

    // A paddle slower than 2 px per frame keeps the base period.
    assign divisor = (estimated_speed < 2) ? 10'd1 : estimated_speed;

    always_comb begin
        hit_period = cnt_w'(base_step_cycles / divisor);
        if (hit_period == '0) begin
            hit_period = 1;
        end
    end

    // Next y and vy for one step, with gravity and the bounce at either edge.
    always_comb begin
        vy_step = (gravity_phase == 2'd3) ? ball_vy + 8'sd1 : ball_vy;
        y_sum = $signed({2'b00, ball_y}) + ball_vy;
        y_step = y_sum[9:0];
        if (y_sum >= $signed({2'b00, y_max})) begin
            y_step = y_max;
            vy_step = -vy_step;
        end else if (y_sum <= 12'sd0) begin
            y_step = '0;
            vy_step = -vy_step;
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            ball_x <= '0;
            ball_y <= start_y;
            ball_vy <= start_vy;
            gravity_phase <= '0;
            step_cnt <= '0;
            step_period <= full_period;
            game_over <= 1'b0;
            send_trigger <= 1'b0;
            is_you_win <= 1'b0;
        end else begin
            state <= state_next;
            ball_x <= ball_x_next;
            ball_y <= ball_y_next;
            ball_vy <= ball_vy_next;
            gravity_phase <= grav_next;
            step_cnt <= step_cnt_next;
            step_period <= step_period_next;
            game_over <= game_over_next;
            send_trigger <= send_trigger_next;
            is_you_win <= is_you_win_next;
        end
    end

    always_comb begin
        state_next = state;
        ball_x_next = ball_x;
        ball_y_next = ball_y;
        ball_vy_next = ball_vy;
        grav_next = gravity_phase;
        step_cnt_next = step_cnt;
        step_period_next = step_period;
        game_over_next = 1'b0;
        send_trigger_next = 1'b0;
        is_you_win_next = is_you_win;
        moving_left = 1'b0;
        moving_right = 1'b0;
        responding = 1'b0;
        contrl_led = 8'b0000_0001;
        do_step = 1'b0;
        serve = 1'b0;

        case (state)
            st_idle: begin
                if (frame_ready && !is_you_win) begin
                    // The peer has sent the ball back. It enters at the right edge.
                    state_next = st_wait;
                    ball_x_next = right_edge_large;
                    ball_y_next = {rx_y_hi[y_hi_lsb +: 2], rx_y_lo};
                    ball_vy_next = vel_t'(rx_vy);
                    grav_next = rx_grav[1:0];
                    step_period_next = rx_speed[flag_bit] ? full_period : full_period >> 1;
                    step_cnt_next = '0;
                end else begin
                    serve = 1'b1;
                    if (game_start) begin
                        state_next = st_running_right;
                        is_you_win_next = 1'b0;
                    end
                end
            end

            st_wait: begin
                contrl_led = 8'b0000_0010;
                responding = 1'b1;
                if (!frame_ready) state_next = st_running_left;
            end

            st_win_flag: begin
                contrl_led = 8'b0000_0100;
                if (frame_ready) begin
                    is_you_win_next = rx_win[flag_bit];
                    state_next = st_wait_win_flag;
                end
            end

            st_wait_win_flag: begin
                contrl_led = 8'b0000_1000;
                responding = 1'b1;
                if (!frame_ready) state_next = st_idle;
            end

            st_stop: begin
                contrl_led = 8'b0001_0000;
                game_over_next = 1'b1;
                if (game_start) begin
                    serve = 1'b1;
                    game_over_next = 1'b0;
                    is_you_win_next = 1'b0;
                    state_next = st_running_right;
                end
            end

            st_send_ball: begin
                contrl_led = 8'b0010_0000;
                send_trigger_next = 1'b1;     // Held until the packer has sent the frame.
                if (send_done) begin
                    send_trigger_next = 1'b0;
                    state_next = st_win_flag;
                end
            end

            st_running_left: begin
                contrl_led = 8'b0100_0000;
                moving_left = 1'b1;
                if (collision) begin
                    state_next = st_running_right;
                    step_cnt_next = '0;
                    step_period_next = hit_period;
                end else if (ball_x == '0) begin
                    state_next = st_stop;
                end else if (step_tick) begin
                    ball_x_next = ball_x - x_step;
                    do_step = 1'b1;
                end else begin
                    step_cnt_next = step_cnt + 1'b1;
                end
            end

            st_running_right: begin
                contrl_led = 8'b1000_0000;
                moving_right = 1'b1;
                if (ball_x >= right_edge) begin
                    state_next = st_send_ball;
                    step_cnt_next = '0;
                end else if (step_tick) begin
                    ball_x_next = ball_x + x_step;
                    do_step = 1'b1;
                end else begin
                    step_cnt_next = step_cnt + 1'b1;
                end
            end

            default: state_next = st_idle;
        endcase

        if (do_step) begin
            step_cnt_next = '0;
            ball_y_next = y_step;
            ball_vy_next = vy_step;
            grav_next = gravity_phase + 2'd1;    // Wraps from 3 to 0 with the gravity kick.
        end

        if (serve) begin
            ball_x_next = '0;
            ball_y_next = start_y;
            ball_vy_next = start_vy;
            grav_next = '0;
            step_cnt_next = '0;
            step_period_next = full_period;
        end
    end

    assert property (@(posedge clk_25MHZ) disable iff (reset) $onehot(contrl_led));

    assert property (@(posedge clk_25MHZ) disable iff (reset) !(moving_left && moving_right));

endmodule

//--- src/link_frame_packer.sv
`timescale 1ns/1ps

module link_frame_packer (
    input  logic                 clk_25MHZ,
    input  logic                 reset,
    input  logic                 send_trigger,
    input  game_pkg::coord_t     ball_y,
    input  game_pkg::vel_t       ball_vy,
    input  game_pkg::grav_t      gravity_phase,
    input  logic                 ball_fast,
    input  logic                 game_over,
    output link_pkg::link_byte_t tx_byte,
    output logic                 tx_valid,
    output logic                 send_done
);
    import game_pkg::*;
    import link_pkg::*;

    localparam int idx_w = $clog2(frame_len);

    coord_t y_q;
    vel_t vy_q;
    grav_t grav_q;
    logic slow_q;
    logic win_q;
    logic trigger_q;
    logic capture;
    logic [idx_w-1:0] byte_idx;

    assign capture = send_trigger && !trigger_q;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            trigger_q <= 1'b0;
            tx_valid <= 1'b0;
            send_done <= 1'b0;
            byte_idx <= '0;
        end else begin
            trigger_q <= send_trigger;
            send_done <= 1'b0;
            if (capture) begin
                tx_valid <= 1'b1;
                byte_idx <= '0;
            end else if (tx_valid) begin
                if (byte_idx == idx_w'(frame_len - 1)) begin
                    tx_valid <= 1'b0;
                    send_done <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (capture) begin
            y_q <= ball_y;
            vy_q <= ball_vy;
            grav_q <= gravity_phase;
            slow_q <= !ball_fast;    // The peer halves its period only when this is 0.
            win_q <= game_over;
        end
    end

    always_comb begin
        tx_byte = '0;
        case (int'(byte_idx))
            idx_y_hi:  tx_byte[y_hi_lsb +: 2] = y_q[9:8];
            idx_y_lo:  tx_byte = y_q[7:0];
            idx_vy:    tx_byte = vy_q;
            idx_grav:  tx_byte[1:0] = grav_q;
            idx_speed: tx_byte[flag_bit] = slow_q;
            idx_win:   tx_byte[flag_bit] = win_q;
            default:   tx_byte = '0;
        endcase
    end

    assert property (@(posedge clk_25MHZ) disable iff (reset)
        capture |=> tx_valid [*frame_len] ##1 !tx_valid);

endmodule

//--- src/link_frame_receiver.sv
`timescale 1ns/1ps

module link_frame_receiver (
    input  logic                 clk_25MHZ,
    input  logic                 reset,
    input  link_pkg::link_byte_t rx_byte,
    input  logic                 rx_valid,
    input  logic                 responding,
    output link_pkg::link_byte_t rx_y_hi,
    output link_pkg::link_byte_t rx_y_lo,
    output link_pkg::link_byte_t rx_vy,
    output link_pkg::link_byte_t rx_grav,
    output link_pkg::link_byte_t rx_speed,
    output link_pkg::link_byte_t rx_win,
    output logic                 frame_ready
);
    import link_pkg::*;

    localparam int idx_w = $clog2(frame_len);

    link_byte_t frame_mem [frame_len];
    logic [idx_w-1:0] byte_idx;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            byte_idx <= '0;
            frame_ready <= 1'b0;
        end else if (frame_ready) begin
            // The frame is held until the controller acknowledges it.
            if (responding) begin
                frame_ready <= 1'b0;
                byte_idx <= '0;
            end
        end else if (rx_valid) begin
            if (byte_idx == idx_w'(frame_len - 1)) begin
                byte_idx <= '0;
                frame_ready <= 1'b1;
            end else begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (rx_valid && !frame_ready) frame_mem[byte_idx] <= rx_byte;
    end

    assign rx_y_hi = frame_mem[idx_y_hi];
    assign rx_y_lo = frame_mem[idx_y_lo];
    assign rx_vy = frame_mem[idx_vy];
    assign rx_grav = frame_mem[idx_grav];
    assign rx_speed = frame_mem[idx_speed];
    assign rx_win = frame_mem[idx_win];

    // The peer must wait for the acknowledge before it sends the next frame.
    assert property (@(posedge clk_25MHZ) disable iff (reset) rx_valid |-> !frame_ready);

endmodule

//--- src/pong_link_top.sv
`timescale 1ns/1ps

module pong_link_top #(
    parameter int unsigned base_step_cycles = 270000
) (
    input  logic                 clk_25MHZ,
    input  logic                 reset,
    input  logic                 upscale,
    input  logic                 game_start,
    input  game_pkg::coord_t     paddle_y,
    input  logic                 frame_tick,
    input  link_pkg::link_byte_t rx_byte,
    input  logic                 rx_valid,
    output link_pkg::link_byte_t tx_byte,
    output logic                 tx_valid,
    output game_pkg::coord_t     ball_x,
    output game_pkg::coord_t     ball_y,
    output logic                 game_over,
    output logic                 is_you_win,
    output logic [7:0]           contrl_led
);
    import game_pkg::*;
    import link_pkg::*;

    coord_t estimated_speed;
    logic collision;
    logic moving_left;
    logic send_trigger;
    logic send_done;
    logic ball_fast;
    logic responding;
    logic frame_ready;
    vel_t ball_vy;
    grav_t gravity_phase;
    link_byte_t rx_y_hi;
    link_byte_t rx_y_lo;
    link_byte_t rx_vy;
    link_byte_t rx_grav;
    link_byte_t rx_speed;
    link_byte_t rx_win;

    paddle_speed_estimator u_speed (
        .clk_25MHZ       (clk_25MHZ),
        .reset           (reset),
        .paddle_y        (paddle_y),
        .frame_tick      (frame_tick),
        .estimated_speed (estimated_speed)
    );

    collision_checker u_collision (
        .clk_25MHZ   (clk_25MHZ),
        .reset       (reset),
        .ball_x      (ball_x),
        .ball_y      (ball_y),
        .paddle_y    (paddle_y),
        .moving_left (moving_left),
        .collision   (collision)
    );

    rally_controller #(
        .base_step_cycles (base_step_cycles)
    ) u_rally (
        .clk_25MHZ       (clk_25MHZ),
        .reset           (reset),
        .upscale         (upscale),
        .game_start      (game_start),
        .collision       (collision),
        .estimated_speed (estimated_speed),
        .frame_ready     (frame_ready),
        .send_done       (send_done),
        .rx_y_hi         (rx_y_hi),
        .rx_y_lo         (rx_y_lo),
        .rx_vy           (rx_vy),
        .rx_grav         (rx_grav),
        .rx_speed        (rx_speed),
        .rx_win          (rx_win),
        .ball_x          (ball_x),
        .ball_y          (ball_y),
        .moving_left     (moving_left),
        .moving_right    (),
        .game_over       (game_over),
        .send_trigger    (send_trigger),
        .ball_vy         (ball_vy),
        .gravity_phase   (gravity_phase),
        .ball_fast       (ball_fast),
        .is_you_win      (is_you_win),
        .responding      (responding),
        .contrl_led      (contrl_led)
    );

    link_frame_packer u_packer (
        .clk_25MHZ     (clk_25MHZ),
        .reset         (reset),
        .send_trigger  (send_trigger),
        .ball_y        (ball_y),
        .ball_vy       (ball_vy),
        .gravity_phase (gravity_phase),
        .ball_fast     (ball_fast),
        .game_over     (game_over),
        .tx_byte       (tx_byte),
        .tx_valid      (tx_valid),
        .send_done     (send_done)
    );

    link_frame_receiver u_receiver (
        .clk_25MHZ   (clk_25MHZ),
        .reset       (reset),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .responding  (responding),
        .rx_y_hi     (rx_y_hi),
        .rx_y_lo     (rx_y_lo),
        .rx_vy       (rx_vy),
        .rx_grav     (rx_grav),
        .rx_speed    (rx_speed),
        .rx_win      (rx_win),
        .frame_ready (frame_ready)
    );

endmodule

//--- tests/tb_pong_checks.svh
`ifndef TB_PONG_CHECKS_SVH
`define TB_PONG_CHECKS_SVH

task automatic check_coord(input coord_t got, input coord_t exp, input string what);
    if (got !== exp) begin
        $display("error %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        stop_on_failure();
    end
endtask

task automatic check_byte(input link_byte_t got, input link_byte_t exp, input string what);
    if (got !== exp) begin
        $display("error %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        stop_on_failure();
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("error %0t ns: %s is %b, expected %b", $time, what, got, exp);
        stop_on_failure();
    end
endtask

task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
        $display("error %0t ns: %s is %0d cycles, expected %0d", $time, what, got, exp);
        stop_on_failure();
    end
endtask

// Polls on falling edges, where the registered outputs are settled.
task automatic wait_led(input logic [7:0] code, input int limit, input string what);
    int n;
    n = 0;
    while (contrl_led !== code) begin
        if (n >= limit) begin
            $display("timeout: the controller never reached the %s state", what);
            stop_on_failure();
        end
        @(negedge clk_25MHZ);
        n++;
    end
endtask

task automatic wait_x_change(input int limit, output int cycles);
    coord_t prev;
    prev = ball_x;
    cycles = 0;
    while (ball_x === prev) begin
        if (cycles >= limit) begin
            $display("timeout: the ball stopped moving at x %0d", prev);
            stop_on_failure();
        end
        @(negedge clk_25MHZ);
        cycles++;
    end
endtask

task automatic wait_tx_valid(input int limit);
    int n;
    n = 0;
    while (tx_valid !== 1'b1) begin
        if (n >= limit) begin
            $display("timeout: no frame was sent at the right edge");
            stop_on_failure();
        end
        @(negedge clk_25MHZ);
        n++;
    end
endtask

task automatic wait_game_over(input int limit);
    int n;
    n = 0;
    while (game_over !== 1'b1) begin
        if (n >= limit) begin
            $display("timeout: game over never came after the miss");
            stop_on_failure();
        end
        @(negedge clk_25MHZ);
        n++;
    end
endtask

// One byte per cycle, as the peer board would send them.
task automatic send_frame(input link_byte_t b0, input link_byte_t b1, input link_byte_t b2,
                          input link_byte_t b3, input link_byte_t b4, input link_byte_t b5);
    link_byte_t bytes [6];
    bytes = '{b0, b1, b2, b3, b4, b5};
    for (int i = 0; i < 6; i++) begin
        rx_byte = bytes[i];
        rx_valid = 1'b1;
        @(negedge clk_25MHZ);
    end
    rx_valid = 1'b0;
    rx_byte = '0;
endtask

`endif

//--- tests/tb_pong_link.sv
`timescale 1ns/1ps

module tb_pong_link;
    import game_pkg::*;
    import link_pkg::*;

    localparam int step_cycles = 40;
    localparam int n_rows = 5;

    // Scenario table, one column per array.
    int row_upscale [n_rows] = '{0, 0, 1, 1, 0};
    int row_y       [n_rows] = '{100, 200, 400, 50, 120};
    int row_vy      [n_rows] = '{2, -4, 5, -1, 1};
    int row_grav    [n_rows] = '{1, 3, 0, 2, 0};
    int row_speed   [n_rows] = '{1, 0, 1, 0, 1};
    int row_win     [n_rows] = '{0, 0, 0, 0, 1};
    int row_return  [n_rows] = '{1, 0, 0, 1, 0};
    int row_swing   [n_rows] = '{4, 0, 0, 3, 0};    // Paddle move in the last frame.

    logic clk_25MHZ;
    logic reset;
    logic upscale;
    logic game_start;
    coord_t paddle_y;
    logic frame_tick;
    link_byte_t rx_byte;
    logic rx_valid;
    link_byte_t tx_byte;
    logic tx_valid;
    coord_t ball_x;
    coord_t ball_y;
    logic game_over;
    logic is_you_win;
    logic [7:0] contrl_led;

    int seed = 32'h776b;
    int m_y;
    int m_vy;
    int m_g;
    int y_max;
    int edge_x;
    int x_exp;
    int cyc;
    int k;
    int stop_x;
    int period;
    int hit_period;
    int y60;
    int y61;
    int y62;
    int tries;
    int p;
    bit found;
    link_byte_t exp_bytes [6];

    pong_link_top #(
        .base_step_cycles (step_cycles)
    ) u_dut (
        .clk_25MHZ  (clk_25MHZ),
        .reset      (reset),
        .upscale    (upscale),
        .game_start (game_start),
        .paddle_y   (paddle_y),
        .frame_tick (frame_tick),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .tx_byte    (tx_byte),
        .tx_valid   (tx_valid),
        .ball_x     (ball_x),
        .ball_y     (ball_y),
        .game_over  (game_over),
        .is_you_win (is_you_win),
        .contrl_led (contrl_led)
    );

    always #20 clk_25MHZ = ~clk_25MHZ;

    task automatic stop_on_failure();
        $display("** FAIL **");
        $fatal(1, "stopped at the first failed check");
    endtask

    `include "tb_pong_checks.svh"

    // One ball step: y gains vy, gravity kicks vy every fourth step, edges reflect.
    task automatic model_step(inout int y, inout int vy, inout int g, input int ymax);
        int vy_next;
        int sum;
        vy_next = (g == 3) ? vy + 1 : vy;
        sum = y + vy;
        if (sum >= ymax) begin
            y = ymax;
            vy = -vy_next;
        end else if (sum <= 0) begin
            y = 0;
            vy = -vy_next;
        end else begin
            y = sum;
            vy = vy_next;
        end
        g = (g + 1) % 4;
    endtask

    task automatic predict_y(input int y, input int vy, input int g, input int ymax,
                             input int steps, output int y_out);
        for (int i = 0; i < steps; i++) begin
            model_step(y, vy, g, ymax);
        end
        y_out = y;
    endtask

    function automatic bit paddle_covers(input int pad, input int y);
        return (y >= pad) && (y <= pad + 40);
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(negedge clk_25MHZ);
        reset = 1'b0;
        @(negedge clk_25MHZ);
    endtask

    // One video frame, on which the paddle position is sampled.
    task automatic pulse_frame_tick();
        frame_tick = 1'b1;
        @(negedge clk_25MHZ);
        frame_tick = 1'b0;
    endtask

    initial begin
        clk_25MHZ = 1'b0;
        reset = 1'b1;
        upscale = 1'b0;
        game_start = 1'b0;
        paddle_y = '0;
        frame_tick = 1'b0;
        rx_byte = '0;
        rx_valid = 1'b0;

        for (int r = 0; r < n_rows; r++) begin
            upscale = row_upscale[r][0];
            paddle_y = 10'd460;
            apply_reset();
            check_coord(ball_x, 10'd0, "ball_x after reset");
            check_coord(ball_y, start_y, "ball_y after reset");
            check_bit(game_over, 1'b0, "game_over after reset");
            check_bit(tx_valid, 1'b0, "tx_valid after reset");
            check_byte(contrl_led, 8'h01, "contrl_led after reset");

            edge_x = row_upscale[r] ? 620 : 300;
            y_max = row_upscale[r] ? 479 : 239;
            m_y = 220;
            m_vy = -3;
            m_g = 0;

            game_start = 1'b1;
            @(negedge clk_25MHZ);
            game_start = 1'b0;

            x_exp = 0;
            k = 0;
            while (x_exp < edge_x) begin
                wait_x_change(4 * step_cycles, cyc);
                x_exp += 10;
                model_step(m_y, m_vy, m_g, y_max);
                check_coord(ball_x, coord_t'(x_exp), "ball_x moving right");
                check_coord(ball_y, coord_t'(m_y), "ball_y moving right");
                if (k > 0) check_count(cyc, step_cycles, "step interval moving right");
                k++;
            end

            // The outgoing frame carries the state of the last step.
            exp_bytes[idx_y_hi] = link_byte_t'((m_y >> 8) << y_hi_lsb);
            exp_bytes[idx_y_lo] = link_byte_t'(m_y & 8'hff);
            exp_bytes[idx_vy] = link_byte_t'(m_vy);
            exp_bytes[idx_grav] = link_byte_t'(m_g);
            exp_bytes[idx_speed] = link_byte_t'(1 << flag_bit);
            exp_bytes[idx_win] = 8'h00;
            wait_tx_valid(20);
            for (int i = 0; i < frame_len; i++) begin
                check_bit(tx_valid, 1'b1, "tx_valid during the frame");
                check_byte(tx_byte, exp_bytes[i], $sformatf("tx byte %0d", i));
                @(negedge clk_25MHZ);
            end
            check_bit(tx_valid, 1'b0, "tx_valid after the frame");

            wait_led(8'h04, 20, "win flag");
            send_frame(8'h00, 8'h00, 8'h00, 8'h00, 8'h00, link_byte_t'(row_win[r] << flag_bit));
            wait_led(8'h01, 20, "idle");

            if (row_win[r] != 0) begin
                check_bit(is_you_win, 1'b1, "is_you_win after a winning frame");
                check_byte(contrl_led, 8'h01, "contrl_led after a winning frame");
            end else begin
                check_bit(is_you_win, 1'b0, "is_you_win after a plain frame");
                predict_y(row_y[r], row_vy[r], row_grav[r], y_max, 60, y60);
                predict_y(row_y[r], row_vy[r], row_grav[r], y_max, 61, y61);
                predict_y(row_y[r], row_vy[r], row_grav[r], y_max, 62, y62);
                if (row_return[r] != 0) begin
                    p = (y60 >= 20) ? y60 - 20 : 0;
                    // The paddle swings onto its spot, which gives the speed estimate.
                    paddle_y = coord_t'(p + row_swing[r]);
                    pulse_frame_tick();
                    paddle_y = coord_t'(p);
                    pulse_frame_tick();
                end else begin
                    tries = 0;
                    found = 1'b0;
                    while (!found) begin
                        if (tries >= 100) begin
                            $display("no paddle position away from the ball was found");
                            stop_on_failure();
                        end
                        p = {$random(seed)} % 400;
                        found = !paddle_covers(p, y60) && !paddle_covers(p, y61) &&
                                !paddle_covers(p, y62);
                        tries++;
                    end
                    paddle_y = coord_t'(p);
                end

                send_frame(link_byte_t'((row_y[r] >> 8) << y_hi_lsb),
                           link_byte_t'(row_y[r] & 8'hff),
                           link_byte_t'(row_vy[r]),
                           link_byte_t'(row_grav[r]),
                           link_byte_t'(row_speed[r] << flag_bit),
                           8'h00);
                wait_led(8'h40, 20, "running left");
                check_coord(ball_x, 10'd620, "ball_x after the peer frame");
                check_coord(ball_y, coord_t'(row_y[r]), "ball_y after the peer frame");

                m_y = row_y[r];
                m_vy = row_vy[r];
                m_g = row_grav[r];
                period = row_speed[r] ? step_cycles : step_cycles / 2;    // Fast frames halve it.
                x_exp = 620;
                k = 0;
                stop_x = row_return[r] ? 20 : 0;
                while (x_exp > stop_x) begin
                    wait_x_change(4 * step_cycles, cyc);
                    x_exp -= 10;
                    model_step(m_y, m_vy, m_g, y_max);
                    check_coord(ball_x, coord_t'(x_exp), "ball_x moving left");
                    check_coord(ball_y, coord_t'(m_y), "ball_y moving left");
                    if (k > 0) check_count(cyc, period, "step interval moving left");
                    k++;
                end

                if (row_return[r] != 0) begin
                    // A faster paddle shortens the step, never below a divisor of 1.
                    hit_period = step_cycles / ((row_swing[r] < 1) ? 1 : row_swing[r]);
                    for (int s = 0; s < 2; s++) begin
                        wait_x_change(4 * step_cycles, cyc);
                        x_exp += 10;
                        model_step(m_y, m_vy, m_g, y_max);
                        check_coord(ball_x, coord_t'(x_exp), "ball_x after the paddle hit");
                        check_coord(ball_y, coord_t'(m_y), "ball_y after the paddle hit");
                    end
                    check_count(cyc, hit_period, "step interval after the paddle hit");
                end else begin
                    wait_game_over(20);
                    check_byte(contrl_led, 8'h10, "contrl_led after the miss");
                end
            end
        end

        $display("** PASS **");
        $finish;
    end

endmodule

//--- list.f
+incdir+tests
src/game_pkg.sv
src/link_pkg.sv
src/paddle_speed_estimator.sv
src/collision_checker.sv
src/rally_controller.sv
src/link_frame_packer.sv
src/link_frame_receiver.sv
src/pong_link_top.sv
tests/tb_pong_link.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pong_link -f list.f -o sim_pong
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_pong 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q '\*\* PASS \*\*'; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
